//--- common/lc3b_types.sv
package lc3b_types;

// Basic data widths.
typedef logic [15:0] lc3b_word;
typedef logic [127:0] lc3b_cache_line;

// Byte address fields as seen by an L1 cache.
// Tag is bits 15 to 7, index bits 6 to 4, word offset bits 3 to 1.
typedef logic [8:0] lc3b_tag;
typedef logic [2:0] lc3b_index;
typedef logic [2:0] lc3b_offset;

// Cache geometry.
localparam int l1_sets = 8;
localparam int victim_entries = 4;

// L1 controller.
typedef enum logic [1:0] {
	l1_idle,
	l1_evict,
	l1_fill
} l1_state_t;

// Victim cache controller.
typedef enum logic [1:0] {
	vc_idle,
	vc_writeback,
	vc_fetch,
	vc_respond
} victim_state_t;

// Line bus arbiter.
typedef enum logic [1:0] {
	arb_idle,
	arb_grant_i,
	arb_grant_d
} arb_state_t;

endpackage : lc3b_types

//--- common/cache_line_if.sv
`timescale 1ns/100ps

interface cache_line_if;
	import lc3b_types::*;

	// Driven by the requester.
	lc3b_word address;
	lc3b_cache_line wdata;
	logic read;
	logic write;
	logic dirty;

	// Driven by the responder.
	lc3b_cache_line rdata;
	logic rdirty;
	logic resp;

	modport requester (output address, wdata, read, write, dirty,
		input rdata, rdirty, resp);

	modport responder (input address, wdata, read, write, dirty,
		output rdata, rdirty, resp);

endinterface : cache_line_if

//--- l1_cache/l1_cache.sv
`timescale 1ns/100ps

module l1_cache
(
	input logic clk,
	input logic reset,

	// CPU side.
	input lc3b_types::lc3b_word mem_address,
	input lc3b_types::lc3b_word mem_wdata,
	input logic mem_read,
	input logic mem_write,
	input logic [1:0] mem_byte_enable,
	output lc3b_types::lc3b_word mem_rdata,
	output logic mem_resp,

	// Line bus towards the arbiter.
	cache_line_if.requester line
);

import lc3b_types::*;

l1_state_t state;

lc3b_cache_line data [l1_sets];
lc3b_tag tags [l1_sets];
logic [l1_sets-1:0] valid;
logic [l1_sets-1:0] dirty;

lc3b_tag tag;
lc3b_index index;
lc3b_offset offset;
logic request;
logic hit;
logic serve;
lc3b_cache_line write_line;

assign tag = mem_address[15:7];
assign index = mem_address[6:4];
assign offset = mem_address[3:1];

assign request = mem_read | mem_write;
assign hit = valid[index] && (tags[index] == tag);

// A held request is served once; the cycle with mem_resp high is skipped.
assign serve = (state == l1_idle) && request && !mem_resp && hit;

// Merge the enabled bytes into the addressed word of the line.
always_comb begin
	write_line = data[index];
	if (mem_byte_enable[0])
		write_line[{offset, 4'd0} +: 8] = mem_wdata[7:0];
	if (mem_byte_enable[1])
		write_line[{offset, 4'd8} +: 8] = mem_wdata[15:8];
end

// Old line goes out during evict, new line address during fill.
assign line.address = (state == l1_evict) ? {tags[index], index, 4'b0000}
	: {mem_address[15:4], 4'b0000};
assign line.wdata = data[index];
assign line.dirty = dirty[index];
assign line.write = (state == l1_evict);
assign line.read = (state == l1_fill);

always_ff @(posedge clk) begin
	if (reset) begin
		state <= l1_idle;
		mem_resp <= 1'b0;
		valid <= '0;
		dirty <= '0;
	end else begin
		mem_resp <= 1'b0;
		case (state)
			l1_idle: begin
				if (serve) begin
					mem_resp <= 1'b1;
					if (mem_write)
						dirty[index] <= 1'b1;
				end else if (request && !mem_resp && !hit) begin
					// Every valid line is handed to the victim cache.
					if (valid[index])
						state <= l1_evict;
					else
						state <= l1_fill;
				end
			end
			l1_evict: begin
				if (line.resp)
					state <= l1_fill;
			end
			l1_fill: begin
				if (line.resp) begin
					valid[index] <= 1'b1;
					// A line returned from the victim cache may still be dirty.
					dirty[index] <= line.rdirty;
					state <= l1_idle;
				end
			end
			default: state <= l1_idle;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (serve) begin
		mem_rdata <= data[index][{offset, 4'd0} +: 16];
		if (mem_write)
			data[index] <= write_line;
	end
	if ((state == l1_fill) && line.resp) begin
		data[index] <= line.rdata;
		tags[index] <= tag;
	end
end

endmodule : l1_cache

//--- logic/cache_arbiter.sv
`timescale 1ns/100ps

module cache_arbiter
(
	input logic clk,
	input logic reset,

	cache_line_if.responder i_line,
	cache_line_if.responder d_line,
	cache_line_if.requester v_line
);

import lc3b_types::*;

arb_state_t state;

// Set when the data cache wins the next tie.
logic prefer_d;

logic i_req;
logic d_req;
logic sel_d;

assign i_req = i_line.read | i_line.write;
assign d_req = d_line.read | d_line.write;
assign sel_d = (state == arb_grant_d);

// Granted requester drives the victim side.
assign v_line.address = sel_d ? d_line.address : i_line.address;
assign v_line.wdata = sel_d ? d_line.wdata : i_line.wdata;
assign v_line.dirty = sel_d ? d_line.dirty : i_line.dirty;
assign v_line.read = (state == arb_grant_i) ? i_line.read
	: (state == arb_grant_d) ? d_line.read : 1'b0;
assign v_line.write = (state == arb_grant_i) ? i_line.write
	: (state == arb_grant_d) ? d_line.write : 1'b0;

// Data is shared, resp only reaches the granted side.
assign i_line.rdata = v_line.rdata;
assign i_line.rdirty = v_line.rdirty;
assign i_line.resp = (state == arb_grant_i) && v_line.resp;
assign d_line.rdata = v_line.rdata;
assign d_line.rdirty = v_line.rdirty;
assign d_line.resp = (state == arb_grant_d) && v_line.resp;

always_ff @(posedge clk) begin
	if (reset) begin
		state <= arb_idle;
		prefer_d <= 1'b0;
	end else begin
		case (state)
			arb_idle: begin
				if (i_req && d_req)
					state <= prefer_d ? arb_grant_d : arb_grant_i;
				else if (d_req)
					state <= arb_grant_d;
				else if (i_req)
					state <= arb_grant_i;
			end
			arb_grant_i, arb_grant_d: begin
				// Release after one transaction and favour the other side.
				if (v_line.resp) begin
					prefer_d <= (state == arb_grant_i);
					state <= arb_idle;
				end
			end
			default: state <= arb_idle;
		endcase
	end
end

endmodule : cache_arbiter

//--- victim_cache/victim_cache.sv
`timescale 1ns/100ps

module victim_cache
(
	input logic clk,
	input logic reset,

	// Line bus from the arbiter.
	cache_line_if.responder line,

	// Physical memory.
	output lc3b_types::lc3b_word pmem_address,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_cache_line pmem_wdata,
	input lc3b_types::lc3b_cache_line pmem_rdata,
	input logic pmem_resp
);

import lc3b_types::*;

typedef logic [$clog2(victim_entries)-1:0] way_t;

victim_state_t state;

// Entries are tagged with the full line address.
lc3b_cache_line data [victim_entries];
lc3b_word tags [victim_entries];
logic [victim_entries-1:0] valid;
logic [victim_entries-1:0] dirty;

// Ages form a permutation, the oldest entry has the highest age.
way_t age [victim_entries];

logic hit;
way_t hit_way;
logic free_found;
way_t repl_way;
way_t slot_q;
logic resp_q;
lc3b_cache_line out_line;
logic out_dirty;

logic store_now;
logic do_store;
way_t store_way;

always_comb begin
	hit = 1'b0;
	hit_way = '0;
	for (int i = 0; i < victim_entries; i++) begin
		if (valid[i] && (tags[i][15:4] == line.address[15:4])) begin
			hit = 1'b1;
			hit_way = way_t'(i);
		end
	end
end

// A free entry is used first, else the LRU one.
always_comb begin
	free_found = 1'b0;
	repl_way = '0;
	for (int i = 0; i < victim_entries; i++)
		if (age[i] == way_t'(victim_entries - 1))
			repl_way = way_t'(i);
	for (int i = 0; i < victim_entries; i++) begin
		if (!valid[i] && !free_found) begin
			free_found = 1'b1;
			repl_way = way_t'(i);
		end
	end
end

// Only a dirty LRU entry delays the store.
assign store_now = (state == vc_idle) && line.write && !resp_q
	&& (free_found || !dirty[repl_way]);
assign do_store = store_now || ((state == vc_writeback) && pmem_resp);
assign store_way = (state == vc_writeback) ? slot_q : repl_way;

assign pmem_read = (state == vc_fetch);
assign pmem_write = (state == vc_writeback);
assign pmem_address = (state == vc_writeback) ? tags[slot_q] : line.address;
assign pmem_wdata = data[slot_q];

assign line.rdata = out_line;
assign line.rdirty = out_dirty;
assign line.resp = resp_q;

always_ff @(posedge clk) begin
	if (reset) begin
		state <= vc_idle;
		resp_q <= 1'b0;
		valid <= '0;
		dirty <= '0;
		slot_q <= '0;
		for (int i = 0; i < victim_entries; i++)
			age[i] <= way_t'(i);
	end else begin
		resp_q <= 1'b0;
		if (do_store) begin
			valid[store_way] <= 1'b1;
			dirty[store_way] <= line.dirty;
			for (int i = 0; i < victim_entries; i++)
				if (age[i] < age[store_way])
					age[i] <= age[i] + 1'b1;
			age[store_way] <= '0;
		end
		case (state)
			vc_idle: begin
				if (!resp_q && line.write) begin
					if (!free_found && dirty[repl_way]) begin
						slot_q <= repl_way;
						state <= vc_writeback;
					end else begin
						state <= vc_respond;
					end
				end else if (!resp_q && line.read) begin
					// The line moves back up, so the entry is freed.
					if (hit) begin
						valid[hit_way] <= 1'b0;
						state <= vc_respond;
					end else begin
						state <= vc_fetch;
					end
				end
			end
			vc_writeback, vc_fetch: begin
				if (pmem_resp)
					state <= vc_respond;
			end
			vc_respond: begin
				resp_q <= 1'b1;
				state <= vc_idle;
			end
			default: state <= vc_idle;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (do_store) begin
		data[store_way] <= line.wdata;
		tags[store_way] <= line.address;
	end
	if ((state == vc_idle) && !resp_q && line.read && hit) begin
		out_line <= data[hit_way];
		out_dirty <= dirty[hit_way];
	end
	if ((state == vc_fetch) && pmem_resp) begin
		out_line <= pmem_rdata;
		out_dirty <= 1'b0;
	end
end

endmodule : victim_cache

//--- logic/memory_hierarchy.sv
`timescale 1ns/100ps

module memory_hierarchy
(
	input logic clk,
	input logic reset,

	// Instruction port.
	input lc3b_types::lc3b_word inst_address,
	input lc3b_types::lc3b_word inst_wdata,
	input logic inst_read,
	input logic inst_write,
	input logic [1:0] inst_byte_enable,
	output lc3b_types::lc3b_word inst_rdata,
	output logic inst_resp,

	// Data port.
	input lc3b_types::lc3b_word data_address,
	input lc3b_types::lc3b_word data_wdata,
	input logic data_read,
	input logic data_write,
	input logic [1:0] data_byte_enable,
	output lc3b_types::lc3b_word data_rdata,
	output logic data_resp,

	// Physical memory.
	output lc3b_types::lc3b_word pmem_address,
	output logic pmem_read,
	output logic pmem_write,
	output lc3b_types::lc3b_cache_line pmem_wdata,
	input lc3b_types::lc3b_cache_line pmem_rdata,
	input logic pmem_resp
);

cache_line_if i_line();
cache_line_if d_line();
cache_line_if v_line();

l1_cache icache_obj
(
	.clk,
	.reset,
	.mem_address(inst_address),
	.mem_wdata(inst_wdata),
	.mem_read(inst_read),
	.mem_write(inst_write),
	.mem_byte_enable(inst_byte_enable),
	.mem_rdata(inst_rdata),
	.mem_resp(inst_resp),
	.line(i_line)
);

l1_cache dcache_obj
(
	.clk,
	.reset,
	.mem_address(data_address),
	.mem_wdata(data_wdata),
	.mem_read(data_read),
	.mem_write(data_write),
	.mem_byte_enable(data_byte_enable),
	.mem_rdata(data_rdata),
	.mem_resp(data_resp),
	.line(d_line)
);

// Both L1 caches share one line bus to the victim cache.
cache_arbiter arbiter_obj
(
	.clk,
	.reset,
	.i_line(i_line),
	.d_line(d_line),
	.v_line(v_line)
);

victim_cache victim_cache_obj
(
	.clk,
	.reset,
	.line(v_line),
	.pmem_address,
	.pmem_read,
	.pmem_write,
	.pmem_wdata,
	.pmem_rdata,
	.pmem_resp
);

endmodule : memory_hierarchy

//--- verif/memory_hierarchy_sva.sv
`timescale 1ns/100ps

module memory_hierarchy_sva
(
	input logic clk,
	input logic reset,
	input lc3b_types::lc3b_word inst_address,
	input logic inst_read,
	input logic inst_write,
	input logic inst_resp,
	input lc3b_types::lc3b_word data_address,
	input logic data_read,
	input logic data_write,
	input logic data_resp,
	input lc3b_types::lc3b_word pmem_address,
	input logic pmem_read,
	input logic pmem_write,
	input logic pmem_resp
);

int unsigned failures = 0;

// Physical memory sees one request at a time.
pmem_exclusive: assert property (@(posedge clk) disable iff (reset)
	!(pmem_read && pmem_write))
	else begin
		$error("pmem_read and pmem_write are high together");
		failures++;
	end

// Requests stay put until their response.
inst_hold: assert property (@(posedge clk) disable iff (reset)
	((inst_read || inst_write) && !inst_resp) |=> $stable({inst_read, inst_write, inst_address}))
	else begin
		$error("instruction request dropped before inst_resp");
		failures++;
	end

data_hold: assert property (@(posedge clk) disable iff (reset)
	((data_read || data_write) && !data_resp) |=> $stable({data_read, data_write, data_address}))
	else begin
		$error("data request dropped before data_resp");
		failures++;
	end

pmem_hold: assert property (@(posedge clk) disable iff (reset)
	((pmem_read || pmem_write) && !pmem_resp) |=> $stable({pmem_read, pmem_write, pmem_address}))
	else begin
		$error("pmem request dropped before pmem_resp");
		failures++;
	end

reset_quiet: assert property (@(posedge clk)
	reset |=> !inst_resp && !data_resp && !pmem_read && !pmem_write)
	else begin
		$error("resp or pmem request high after reset");
		failures++;
	end

endmodule : memory_hierarchy_sva

bind memory_hierarchy memory_hierarchy_sva assertions0 (.*);

//--- verif/memory_hierarchy_tb.sv
`timescale 1ns/100ps

module memory_hierarchy_tb;

import lc3b_types::*;

// One table row is one CPU request.
typedef struct packed {
	logic par;
	logic data_port;
	logic write;
	lc3b_word address;
	lc3b_word wdata;
	logic [1:0] be;
	logic fill;
} row_t;

localparam int num_rows = 28;

logic clk;
logic reset;
lc3b_word inst_address;
lc3b_word inst_wdata;
logic inst_read;
logic inst_write;
logic [1:0] inst_byte_enable;
lc3b_word inst_rdata;
logic inst_resp;
lc3b_word data_address;
lc3b_word data_wdata;
logic data_read;
logic data_write;
logic [1:0] data_byte_enable;
lc3b_word data_rdata;
logic data_resp;
lc3b_word pmem_address;
logic pmem_read;
logic pmem_write;
lc3b_cache_line pmem_wdata;
lc3b_cache_line pmem_rdata;
logic pmem_resp;

int seed = 32'h40b4_b893;
int pmem_reads = 0;
lc3b_cache_line mem [4096];
bit line_written [4096];
lc3b_word ref_words [32768];

// Fields: par, data port, write, address, wdata, byte enable, expects a pmem read.
// Index 1 of the data cache is cycled through to push 0x8010 out of the victim cache.
row_t rows [num_rows] = '{
	'{1'b0, 1'b1, 1'b0, 16'h8010, 16'h0000, 2'b11, 1'b1},
	'{1'b0, 1'b1, 1'b0, 16'h8012, 16'h0000, 2'b11, 1'b0},
	'{1'b0, 1'b1, 1'b1, 16'h8012, 16'ha5c3, 2'b01, 1'b0},
	'{1'b0, 1'b1, 1'b0, 16'h8012, 16'h0000, 2'b11, 1'b0},
	'{1'b0, 1'b1, 1'b1, 16'h8014, 16'h1234, 2'b10, 1'b0},
	'{1'b0, 1'b1, 1'b0, 16'h8014, 16'h0000, 2'b11, 1'b0},
	'{1'b0, 1'b1, 1'b1, 16'h8016, 16'hbeef, 2'b11, 1'b0},
	'{1'b0, 1'b1, 1'b0, 16'h8016, 16'h0000, 2'b11, 1'b0},
	'{1'b0, 1'b1, 1'b0, 16'h8090, 16'h0000, 2'b11, 1'b1},
	'{1'b0, 1'b1, 1'b0, 16'h8012, 16'h0000, 2'b11, 1'b0},
	'{1'b0, 1'b1, 1'b0, 16'h8110, 16'h0000, 2'b11, 1'b1},
	'{1'b0, 1'b1, 1'b0, 16'h8190, 16'h0000, 2'b11, 1'b1},
	'{1'b0, 1'b1, 1'b0, 16'h8210, 16'h0000, 2'b11, 1'b1},
	'{1'b0, 1'b1, 1'b0, 16'h8290, 16'h0000, 2'b11, 1'b1},
	'{1'b0, 1'b1, 1'b0, 16'h8310, 16'h0000, 2'b11, 1'b1},
	'{1'b0, 1'b1, 1'b0, 16'h8012, 16'h0000, 2'b11, 1'b1},
	'{1'b0, 1'b1, 1'b0, 16'h8014, 16'h0000, 2'b11, 1'b0},
	'{1'b0, 1'b1, 1'b0, 16'h8016, 16'h0000, 2'b11, 1'b0},
	'{1'b1, 1'b0, 1'b0, 16'h0100, 16'h0000, 2'b11, 1'b1},
	'{1'b0, 1'b1, 1'b0, 16'h8200, 16'h0000, 2'b11, 1'b1},
	'{1'b1, 1'b0, 1'b0, 16'h0180, 16'h0000, 2'b11, 1'b1},
	'{1'b0, 1'b1, 1'b0, 16'h8280, 16'h0000, 2'b11, 1'b1},
	'{1'b1, 1'b0, 1'b0, 16'h0102, 16'h0000, 2'b11, 1'b0},
	'{1'b0, 1'b1, 1'b0, 16'h8204, 16'h0000, 2'b11, 1'b0},
	'{1'b1, 1'b0, 1'b1, 16'h0104, 16'h5a5a, 2'b11, 1'b0},
	'{1'b0, 1'b1, 1'b1, 16'h8206, 16'h00ff, 2'b01, 1'b0},
	'{1'b0, 1'b0, 1'b0, 16'h0104, 16'h0000, 2'b11, 1'b0},
	'{1'b0, 1'b1, 1'b0, 16'h8206, 16'h0000, 2'b11, 1'b0}
};

memory_hierarchy dut0 (.*);

initial begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
	input string what);
	if (actual !== expected) begin
		$display("MISMATCH at %0t ns: %s (got %h, expected %h)", $time, what, actual,
			expected);
		$display("TEST FAILED");
		$fatal(1, "Check failed.");
	end
endtask

task automatic drive_port(input row_t r, input logic active);
	if (r.data_port) begin
		data_address = r.address;
		data_wdata = r.wdata;
		data_byte_enable = r.be;
		data_read = active && !r.write;
		data_write = active && r.write;
	end else begin
		inst_address = r.address;
		inst_wdata = r.wdata;
		inst_byte_enable = r.be;
		inst_read = active && !r.write;
		inst_write = active && r.write;
	end
endtask

// Issues one or two rows together and waits for every response.
task automatic apply_rows(input int first, input int count);
	logic [1:0] busy;
	int reads_before;
	int fills_expected;
	lc3b_word actual;
	logic resp;
	row_t r;
	busy = 2'b00;
	reads_before = pmem_reads;
	fills_expected = 0;
	for (int k = first; k < first + count; k++) begin
		r = rows[k];
		fills_expected = fills_expected + int'(r.fill);
		busy[r.data_port] = 1'b1;
		drive_port(r, 1'b1);
	end
	while (busy != 2'b00) begin
		@(negedge clk);
		for (int k = first; k < first + count; k++) begin
			r = rows[k];
			resp = r.data_port ? data_resp : inst_resp;
			actual = r.data_port ? data_rdata : inst_rdata;
			if (busy[r.data_port] && resp) begin
				busy[r.data_port] = 1'b0;
				if (r.write) begin
					// Only the enabled bytes of the word change.
					if (r.be[0])
						ref_words[r.address[15:1]][7:0] = r.wdata[7:0];
					if (r.be[1])
						ref_words[r.address[15:1]][15:8] = r.wdata[15:8];
				end else begin
					check_equal(32'(actual), 32'(ref_words[r.address[15:1]]),
						$sformatf("row %0d read of %h", k, r.address));
				end
			end
		end
		@(posedge clk);
		#5;
		for (int k = first; k < first + count; k++)
			if (!busy[rows[k].data_port])
				drive_port(rows[k], 1'b0);
	end
	check_equal(32'(pmem_reads - reads_before), 32'(fills_expected),
		$sformatf("pmem reads for row %0d", first));
endtask

// Physical memory answers after 1 to 4 cycles with a one cycle pmem_resp.
initial begin
	int delay;
	pmem_resp = 1'b0;
	pmem_rdata = '0;
	forever begin
		@(posedge clk);
		#5;
		if (pmem_read || pmem_write) begin
			delay = 1 + ($random(seed) & 3);
			repeat (delay - 1) begin
				@(posedge clk);
				#5;
			end
			if (pmem_write) begin
				mem[pmem_address[15:4]] = pmem_wdata;
				line_written[pmem_address[15:4]] = 1'b1;
			end else begin
				pmem_rdata = mem[pmem_address[15:4]];
				pmem_reads++;
			end
			pmem_resp = 1'b1;
			@(posedge clk);
			#5;
			pmem_resp = 1'b0;
		end
	end
end

initial begin
	repeat (num_rows * 40 + 10) @(posedge clk);
	$display("Timeout: the requests did not complete within %0d cycles.",
		num_rows * 40 + 10);
	$display("TEST FAILED");
	$fatal(1, "Timeout.");
end

initial begin
	logic [11:0] line_addr;
	logic [2:0] word_sel;
	int i;
	reset = 1'b1;
	inst_address = '0;
	inst_wdata = '0;
	inst_read = 1'b0;
	inst_write = 1'b0;
	inst_byte_enable = 2'b00;
	data_address = '0;
	data_wdata = '0;
	data_read = 1'b0;
	data_write = 1'b0;
	data_byte_enable = 2'b00;
	for (int a = 0; a < 4096; a++)
		mem[12'(a)] = {$random(seed), $random(seed), $random(seed), $random(seed)};
	for (int a = 0; a < 32768; a++) begin
		line_addr = 12'(a >> 3);
		word_sel = 3'(a);
		ref_words[15'(a)] = mem[line_addr][{word_sel, 4'd0} +: 16];
	end
	repeat (10) @(posedge clk);
	#5;
	reset = 1'b0;
	check_equal(32'({inst_resp, data_resp, pmem_read, pmem_write}), 32'd0,
		"resp and pmem requests after reset");
	i = 0;
	while (i < num_rows) begin
		if (rows[i].par) begin
			apply_rows(i, 2);
			i = i + 2;
		end else begin
			apply_rows(i, 1);
			i = i + 1;
		end
	end
	// The dirty line 0x8010 must have been dropped to memory on the way.
	check_equal(32'(line_written[12'h801]), 32'd1, "pmem write of line 8010");
	if (dut0.assertions0.failures == 0) begin
		$display("TEST OK");
		$finish;
	end else begin
		$display("TEST FAILED");
		$fatal(1, "Assertions failed during the run.");
	end
end

endmodule : memory_hierarchy_tb

//--- project.f
common/lc3b_types.sv
common/cache_line_if.sv
l1_cache/l1_cache.sv
logic/cache_arbiter.sv
victim_cache/victim_cache.sv
logic/memory_hierarchy.sv
verif/memory_hierarchy_sva.sv
verif/memory_hierarchy_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= memory_hierarchy_tb
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q '^TEST OK$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
